// File: logic/core_pkg.sv
package core_pkg;

  localparam int XLEN            = 64;
  localparam int ILEN            = 32;
  localparam int NUM_REGS        = 32;
  localparam int INST_BYTES      = 4;
  localparam int SLOTS_PER_BLOCK = 16;  // 64-byte block of 4-byte instructions

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [ILEN-1:0]             inst_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [6:0]                  opcode_t;
  typedef logic [2:0]                  funct3_t;
  typedef logic [5:0]                  shamt_t;  // rv64 shifts take 6 bits

  // major opcodes handled by the execute unit
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  // funct3 encodings shared by OP and OP-IMM
  localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // srl / sra picked by bit 30
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam reg_idx_t REG_SP = 5'd2;  // stack pointer, x2

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,  // lui
    alu_none     // unsupported, retires without a write
  } alu_op_t;

endpackage

// File: logic/bus_pkg.sv
package bus_pkg;

  localparam int BUS_DATA_BITS = 64;
  localparam int REQ_NUM_BITS  = 12;
  localparam int BLOCK_BEATS   = 8;
  localparam int BLOCK_BITS    = BLOCK_BEATS * BUS_DATA_BITS;  // 64 bytes

  typedef logic [BUS_DATA_BITS-1:0] bus_data_t;  // address rides the same lines
  typedef logic [REQ_NUM_BITS-1:0]  req_num_t;
  typedef logic [REQ_NUM_BITS:0]    bus_tag_t;   // {read bit, request number}
  typedef logic [BLOCK_BITS-1:0]    block_t;     // beat 0 in the low bits

  // upper tag bit marks a read request
  localparam logic TAG_READ = 1'b1;

endpackage

// File: logic/mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl
  import core_pkg::*;
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      blk_start,
  input  word_t     blk_addr,
  output logic      blk_done,
  output block_t    blk_data,
  output logic      bus_reqcyc,
  output logic      bus_respack,
  output bus_data_t bus_req,
  output bus_tag_t  bus_reqtag,
  input  logic      bus_respcyc,
  input  logic      bus_reqack,
  input  bus_data_t bus_resp,
  input  bus_tag_t  bus_resptag
);

  localparam int BEAT_BITS = $clog2(BLOCK_BEATS);

  typedef enum logic [1:0] {idle, request, collect, done} state_t;

  state_t               state;
  req_num_t             req_num;
  logic [BEAT_BITS-1:0] beat_cnt;
  bus_data_t            addr_q;
  bus_tag_t             cur_tag;
  logic                 beat_ok;

  assign cur_tag = {TAG_READ, req_num};
  // only beats carrying our outstanding tag are taken
  assign beat_ok = (state == collect) && bus_respcyc && (bus_resptag == cur_tag);

  assign bus_reqcyc  = (state == request);  // held until acked
  assign bus_req     = addr_q;
  assign bus_reqtag  = cur_tag;
  assign bus_respack = beat_ok;
  assign blk_done    = (state == done);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      req_num  <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (blk_start) begin
            state   <= request;
            req_num <= req_num + 1'b1;  // fresh tag per read
          end
        end
        request: begin
          if (bus_reqack) begin
            state    <= collect;
            beat_cnt <= '0;
          end
        end
        collect: begin
          if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BEAT_BITS'(BLOCK_BEATS - 1)) state <= done;
          end
        end
        default: state <= idle;  // done lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && blk_start) addr_q <= blk_addr;
    if (beat_ok) blk_data[beat_cnt*BUS_DATA_BITS +: BUS_DATA_BITS] <= bus_resp;
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
  import core_pkg::*;
  import bus_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic                       clk,
  input  logic                       reset,
  input  word_t                      entry,
  output logic                       blk_start,
  output word_t                      blk_addr,
  input  logic                       blk_done,
  input  block_t                     blk_data,
  input  logic [$clog2(QUEUE_DEPTH):0] free_count,
  output logic                       push,
  output inst_t                      push_inst,
  output word_t                      push_pc
);

  localparam int SLOT_BITS   = $clog2(SLOTS_PER_BLOCK);
  localparam int BYTE_BITS   = $clog2(INST_BYTES);
  localparam int OFF_BITS    = SLOT_BITS + BYTE_BITS;
  localparam int BLOCK_BYTES = SLOTS_PER_BLOCK * INST_BYTES;

  typedef enum logic [1:0] {wait_space, wait_block, emit} state_t;

  state_t               state;
  word_t                pc;
  block_t               blk_q;
  logic [SLOT_BITS-1:0] slot;
  logic                 room;

  // a whole block must fit before we ask for one
  assign room = (free_count >= SLOTS_PER_BLOCK);

  assign blk_addr  = {pc[XLEN-1:OFF_BITS], {OFF_BITS{1'b0}}};
  assign push      = (state == emit);
  assign push_inst = blk_q[slot*ILEN +: ILEN];
  assign push_pc   = {pc[XLEN-1:OFF_BITS], slot, {BYTE_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= wait_space;
      pc        <= entry;
      blk_start <= 1'b0;
      slot      <= '0;
    end else begin
      blk_start <= 1'b0;
      case (state)
        wait_space: begin
          if (room) begin
            blk_start <= 1'b1;
            state     <= wait_block;
          end
        end
        wait_block: begin
          if (blk_done) begin
            slot  <= pc[OFF_BITS-1:BYTE_BITS];  // start mid-block after a jump in entry
            state <= emit;
          end
        end
        default: begin
          slot <= slot + 1'b1;
          if (slot == SLOT_BITS'(SLOTS_PER_BLOCK - 1)) begin
            state <= wait_space;
            pc    <= blk_addr + BLOCK_BYTES;  // next sequential block
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == wait_block && blk_done) blk_q <= blk_data;
  end

endmodule

// File: logic/inst_queue.sv
`timescale 1ns/100ps

module inst_queue
  import core_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  inst_t                        push_inst,
  input  word_t                        push_pc,
  input  logic                         pop,
  output logic                         empty,
  output inst_t                        head_inst,
  output word_t                        head_pc,
  output logic [$clog2(QUEUE_DEPTH):0] free_count
);

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

  typedef logic [PTR_BITS:0] count_t;

  inst_t               inst_mem [QUEUE_DEPTH];
  word_t               pc_mem   [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  count_t              count;

  assign empty      = (count == '0);
  assign head_inst  = inst_mem[rd_ptr];  // show-ahead
  assign head_pc    = pc_mem[rd_ptr];
  assign free_count = count_t'(QUEUE_DEPTH) - count;

  always_ff @(posedge clk) begin
    if (push) begin
      inst_mem[wr_ptr] <= push_inst;
      pc_mem[wr_ptr]   <= push_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap on their own
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/100ps

module exec_unit
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    stackptr,
  input  logic     empty,
  input  inst_t    head_inst,
  input  word_t    head_pc,
  output logic     pop,
  output logic     retire_valid,
  output word_t    retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_data
);

  word_t    regs [NUM_REGS];
  opcode_t  opcode;
  funct3_t  funct3;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm_i;
  word_t    imm_u;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    op_a;
  word_t    op_b;
  word_t    result;
  shamt_t   shamt;
  alu_op_t  op;
  logic     writes;

  assign pop = !empty;  // one instruction per cycle, never stalls

  assign opcode = head_inst[6:0];
  assign rd     = head_inst[11:7];
  assign funct3 = head_inst[14:12];
  assign rs1    = head_inst[19:15];
  assign rs2    = head_inst[24:20];
  assign imm_i  = {{52{head_inst[31]}}, head_inst[31:20]};
  assign imm_u  = {{32{head_inst[31]}}, head_inst[31:12], 12'b0};

  // bypass the result still sitting in the retire register
  // retire_rd is 0 with data 0 for no-ops and x0 writes, so x0 reads stay 0
  assign rs1_val = (retire_valid && retire_rd == rs1) ? retire_data : regs[rs1];
  assign rs2_val = (retire_valid && retire_rd == rs2) ? retire_data : regs[rs2];

  always_comb begin
    op   = alu_none;
    op_a = rs1_val;
    op_b = imm_i;
    case (opcode)
      OPC_OP_IMM, OPC_OP: begin
        if (opcode == OPC_OP) op_b = rs2_val;
        case (funct3)
          F3_ADD:  op = (opcode == OPC_OP && head_inst[30]) ? alu_sub : alu_add;
          F3_SLL:  op = alu_sll;
          F3_SLT:  op = alu_slt;
          F3_SLTU: op = alu_sltu;
          F3_XOR:  op = alu_xor;
          F3_SR:   op = head_inst[30] ? alu_sra : alu_srl;
          F3_OR:   op = alu_or;
          default: op = alu_and;
        endcase
      end
      OPC_LUI: begin
        op   = alu_pass_b;
        op_b = imm_u;
      end
      OPC_AUIPC: begin
        op   = alu_add;
        op_a = head_pc;
        op_b = imm_u;
      end
      default: op = alu_none;
    endcase
  end

  assign writes = (op != alu_none);
  assign shamt  = op_b[5:0];  // imm_i low bits hold the I-type shamt

  always_comb begin
    case (op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_sll:    result = op_a << shamt;
      alu_slt:    result = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu:   result = word_t'(op_a < op_b);
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = word_t'($signed(op_a) >>> shamt);
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) retire_valid <= 1'b0;
    else retire_valid <= pop;
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      retire_pc   <= head_pc;
      retire_rd   <= writes ? rd : '0;
      retire_data <= (writes && rd != '0) ? result : '0;  // x0 reports 0
    end
  end

  // register file takes the write as the retire report leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= (i == REG_SP) ? stackptr : '0;
    end else if (retire_valid && retire_rd != '0) begin
      regs[retire_rd] <= retire_data;
    end
  end

endmodule

// File: logic/core_top.sv
`timescale 1ns/100ps

module core_top
  import core_pkg::*;
  import bus_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic      clk,
  input  logic      reset,
  input  word_t     entry,     // first instruction address
  input  word_t     stackptr,  // initial x2
  output logic      bus_reqcyc,
  output logic      bus_respack,
  output bus_data_t bus_req,
  output bus_tag_t  bus_reqtag,
  input  logic      bus_respcyc,
  input  logic      bus_reqack,
  input  bus_data_t bus_resp,
  input  bus_tag_t  bus_resptag,
  output logic      retire_valid,
  output word_t     retire_pc,
  output reg_idx_t  retire_rd,
  output word_t     retire_data
);

  logic                         blk_start;
  word_t                        blk_addr;
  logic                         blk_done;
  block_t                       blk_data;
  logic                         push;
  inst_t                        push_inst;
  word_t                        push_pc;
  logic [$clog2(QUEUE_DEPTH):0] free_count;
  logic                         pop;
  logic                         empty;
  inst_t                        head_inst;
  word_t                        head_pc;

  mem_ctrl mem_ctrl_inst (
    .clk, .reset, .blk_start, .blk_addr, .blk_done, .blk_data,
    .bus_reqcyc, .bus_respack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_reqack, .bus_resp, .bus_resptag
  );

  fetch_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetch_unit_inst (
    .clk, .reset, .entry, .blk_start, .blk_addr, .blk_done, .blk_data,
    .free_count, .push, .push_inst, .push_pc
  );

  inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_inst (
    .clk, .reset, .push, .push_inst, .push_pc, .pop,
    .empty, .head_inst, .head_pc, .free_count
  );

  exec_unit exec_unit_inst (
    .clk, .reset, .stackptr, .empty, .head_inst, .head_pc, .pop,
    .retire_valid, .retire_pc, .retire_rd, .retire_data
  );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  initial reset = 1'b1;

  // raises reset and returns 1 ns after an edge with reset still high
  // so memory and inputs can be set before the third reset edge
  task automatic hold_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic release_reset();
    @(posedge clk);
    #1 reset = 1'b0;
  endtask

endmodule

// File: tb/bus_mem_model.sv
`timescale 1ns/100ps

module bus_mem_model
  import core_pkg::*;
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      bus_reqcyc,
  input  logic      bus_respack,
  input  bus_data_t bus_req,
  input  bus_tag_t  bus_reqtag,
  output logic      bus_respcyc,
  output logic      bus_reqack,
  output bus_data_t bus_resp,
  output bus_tag_t  bus_resptag
);

  localparam int WORDS = 1024;

  inst_t    mem [WORDS];
  word_t    base;
  int       ack_max = 0;  // random delay knobs, 0 means no delay
  int       gap_max = 0;
  bit       strays = 0;
  int       good_beats = 0;
  int       req_count = 0;
  int       errors = 0;
  word_t    first_addr;
  bus_tag_t first_tag;
  bit       hit;  // reset seen while serving

  initial begin
    bus_respcyc = 1'b0;
    bus_reqack  = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
  end

  // custom-0 opcode, never executed as a real op
  function automatic inst_t fill(word_t a);
    return {a[24:0] ^ a[49:25] ^ {11'b0, a[63:50]}, 7'b0001011};
  endfunction

  function automatic inst_t read_word(word_t a);
    word_t off;
    off = a - base;
    return (off < WORDS * INST_BYTES) ? mem[off / INST_BYTES] : fill(a);
  endfunction

  task automatic clear(word_t b);
    base = b;
    for (int i = 0; i < WORDS; i++) mem[i] = fill(b + i * INST_BYTES);
    good_beats = 0;
    req_count  = 0;
  endtask

  task automatic write(word_t a, inst_t w);
    mem[(a - base) / INST_BYTES] = w;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
    if (reset) hit = 1'b1;
  endtask

  task automatic serve(word_t a, bus_tag_t tag);
    hit = 1'b0;
    if (req_count == 0) begin
      first_addr = a;
      first_tag  = tag;
    end
    req_count++;
    repeat ($urandom_range(ack_max, 0)) step();
    if (hit) return;
    bus_reqack = 1'b1;
    step();
    bus_reqack = 1'b0;
    for (int b = 0; b < BLOCK_BEATS && !hit; b++) begin
      repeat ($urandom_range(gap_max, 0)) begin
        bus_respcyc = strays && $urandom_range(1, 0);
        bus_resptag = tag ^ 13'h1;  // wrong tag, must be ignored
        bus_resp    = '1;
        #2 if (bus_respcyc && bus_respack) begin
          $display("respack given to a beat with a foreign tag at %0t", $time);
          errors++;
        end
        step();
      end
      bus_respcyc = 1'b1;
      bus_resptag = tag;
      bus_resp    = {read_word(a + 8 * b + 4), read_word(a + 8 * b)};
      #2 if (!reset && !hit && !bus_respack) begin
        $display("respack missing for beat %0d at %0t", b, $time);
        errors++;
      end
      good_beats++;
      step();
      bus_respcyc = 1'b0;
    end
    bus_respcyc = 1'b0;
  endtask

  always begin
    @(posedge clk);
    #1;
    if (!reset && bus_reqcyc) serve(bus_req, bus_reqtag);
  end

endmodule

// File: tb/core_tb.sv
`timescale 1ns/100ps

module core_tb import core_pkg::*, bus_pkg::*;;

  localparam int TOTAL_INSTS = 150;  // sum of all test programs

  logic clk, reset, bus_respcyc, bus_reqack, bus_reqcyc, bus_respack, retire_valid;
  word_t entry, stackptr, retire_pc, retire_data;
  bus_data_t bus_req, bus_resp;
  bus_tag_t bus_reqtag, bus_resptag;
  reg_idx_t retire_rd;

  inst_t prog[$];
  word_t ref_regs [32];
  int    errors = 0;
  int    tests = 0;
  int    fails = 0;

  tb_clock clk_gen (.clk, .reset);

  bus_mem_model mem_model (
    .clk, .reset, .bus_reqcyc, .bus_respack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_reqack, .bus_resp, .bus_resptag
  );

  core_top #(.QUEUE_DEPTH(32)) core_top_inst (
    .clk, .reset, .entry, .stackptr, .bus_reqcyc, .bus_respack, .bus_req, .bus_reqtag,
    .bus_respcyc, .bus_reqack, .bus_resp, .bus_resptag,
    .retire_valid, .retire_pc, .retire_rd, .retire_data
  );

  function automatic inst_t i_op(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic inst_t r_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                 reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t u_op(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // rv64 rules, independent of the decoder in the DUT
  function automatic word_t ref_exec(inst_t i, word_t pc, output reg_idx_t rd);
    word_t a, b, r;
    logic [5:0] sh;
    a  = ref_regs[i[19:15]];
    b  = (i[6:0] == 7'b0110011) ? ref_regs[i[24:20]] : {{52{i[31]}}, i[31:20]};
    sh = b[5:0];
    rd = i[11:7];
    case (i[6:0])
      7'b0110111: r = {{32{i[31]}}, i[31:12], 12'h0};
      7'b0010111: r = pc + {{32{i[31]}}, i[31:12], 12'h0};
      7'b0010011, 7'b0110011: begin
        case (i[14:12])
          3'd0: r = (i[5] && i[30]) ? a - b : a + b;  // sub only in the R form
          3'd1: r = a << sh;
          3'd2: r = {63'b0, $signed(a) < $signed(b)};
          3'd3: r = {63'b0, a < b};
          3'd4: r = a ^ b;
          3'd5: r = i[30] ? word_t'($signed(a) >>> sh) : a >> sh;
          3'd6: r = a | b;
          default: r = a & b;
        endcase
      end
      default: rd = '0;  // no-op
    endcase
    if (rd == '0) r = '0;
    else ref_regs[rd] = r;
    return r;
  endfunction

  task automatic run_program(string name, word_t entry_pc, word_t sp, bit check_start);
    int waited, errs;
    reg_idx_t exp_rd;
    word_t exp_data, pc;
    errs = errors + mem_model.errors;
    clk_gen.hold_reset();
    mem_model.clear({entry_pc[63:6], 6'b0});
    foreach (prog[k]) mem_model.write(entry_pc + 4 * k, prog[k]);
    entry    = entry_pc;
    stackptr = sp;
    ref_regs = '{default: '0};
    ref_regs[2] = sp;
    clk_gen.release_reset();
    pc = entry_pc;
    for (int k = 0; k < prog.size(); k++) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!retire_valid && waited < 400);
      if (!retire_valid) begin
        $display("%s: no retire for instruction %0d within 400 cycles", name, k);
        errors++;
        break;
      end
      if (check_start && k == 0 && mem_model.good_beats < BLOCK_BEATS) begin
        $display("%s: retire seen before the first block arrived", name);
        errors++;
      end
      exp_data = ref_exec(prog[k], pc, exp_rd);
      if (retire_pc != pc || retire_rd != exp_rd || retire_data != exp_data) begin
        $display("Mismatch at %0t: %s #%0d got pc %h rd %0d data %h, want pc %h rd %0d data %h",
                 $time, name, k, retire_pc, retire_rd, retire_data, pc, exp_rd, exp_data);
        errors++;
      end
      pc += 4;
    end
    if (check_start && (mem_model.first_addr != {entry_pc[63:6], 6'b0} ||
                        !mem_model.first_tag[12])) begin
      $display("Mismatch at %0t: first request %h tag %h", $time, mem_model.first_addr,
               mem_model.first_tag);
      errors++;
    end
    tests++;
    if (errors + mem_model.errors != errs) fails++;
    $display("%s: %s", name, (errors + mem_model.errors == errs) ? "pass" : "fail");
    prog.delete();
  endtask

  task automatic reset_and_start();
    prog = '{i_op(0, 5, 2, 0), i_op(0, 6, 0, -5), r_op(0, 0, 7, 5, 6)};
    run_program("reset_start", 64'h8000_0018, {$urandom, $urandom}, 1);
  endtask

  task automatic immediate_ops();
    reg_idx_t srcs [2] = '{1, 10};
    logic [2:0] f3s [6] = '{0, 2, 3, 4, 6, 7};
    prog = '{u_op(7'b0110111, 1, $urandom), i_op(0, 1, 1, $urandom),
             u_op(7'b0110111, 10, {1'b1, 19'($urandom)}), i_op(0, 4, 2, 0)};
    foreach (srcs[s]) begin
      foreach (f3s[f]) prog.push_back(i_op(f3s[f], 11 + f, srcs[s], $urandom));
      prog.push_back(i_op(1, 20, srcs[s], {6'b0, 6'($urandom)}));
      prog.push_back(i_op(5, 21, srcs[s], {6'b0, 6'($urandom)}));
      prog.push_back(i_op(5, 22, srcs[s], {6'b010000, 6'($urandom)}));  // srai
    end
    run_program("imm_ops", 64'h2000, {$urandom, $urandom}, 0);
  endtask

  task automatic register_ops();
    reg_idx_t pairs [8] = '{1, 3, 7, 8, 8, 9, 9, 7};
    logic [9:0] ops [10] = '{0, 10'h100, 1, 2, 3, 4, 5, 10'h105, 6, 7};  // {f7[5], f3}
    prog = '{u_op(7'b0110111, 1, $urandom), i_op(0, 1, 1, $urandom),
             u_op(7'b0110111, 3, $urandom), i_op(0, 3, 3, $urandom),
             u_op(7'b0110111, 7, 20'h80000), i_op(0, 8, 0, -1), i_op(0, 9, 0, 1)};
    for (int p = 0; p < 8; p += 2)
      foreach (ops[o]) prog.push_back(r_op({1'b0, ops[o][8], 5'b0}, ops[o][2:0], 12 + o,
                                           pairs[p], pairs[p + 1]));
    run_program("reg_ops", 64'h3040, {$urandom, $urandom}, 0);
  endtask

  task automatic dependent_chain();
    prog = '{i_op(0, 5, 0, $urandom)};
    for (int k = 0; k < 12; k++) begin
      case (k % 3)
        0: prog.push_back(i_op(0, 5, 5, $urandom));
        1: prog.push_back(r_op(0, 0, 5, 5, 5));
        default: prog.push_back(r_op(0, 4, 5, 5, 2));
      endcase
    end
    prog.push_back(i_op(0, 0, 5, 7));  // x0 write is dropped
    prog.push_back(r_op(0, 0, 11, 0, 5));
    run_program("dep_chain", 64'h4000, {$urandom, $urandom}, 0);
  endtask

  task automatic random_bus_stream();
    logic [2:0] f3;
    mem_model.ack_max = 4;
    mem_model.gap_max = 3;
    mem_model.strays  = 1;
    for (int k = 0; k < 56; k++) begin
      f3 = $urandom;
      case ($urandom_range(3, 0))
        0: prog.push_back(i_op(f3, $urandom, $urandom, (f3 == 1 || f3 == 5) ?
                                {1'b0, 1'($urandom), 4'b0, 6'($urandom)} : 12'($urandom)));
        1: prog.push_back(r_op({1'b0, (f3 == 0 || f3 == 5) && $urandom_range(1, 0), 5'b0},
                               f3, $urandom, $urandom, $urandom));
        2: prog.push_back(u_op(7'b0110111, $urandom, $urandom));
        default: prog.push_back(u_op(7'b0010111, $urandom, $urandom));
      endcase
    end
    run_program("random_bus", 64'h1000, {$urandom, $urandom}, 0);
    mem_model.ack_max = 0;
    mem_model.gap_max = 0;
    mem_model.strays  = 0;
  endtask

  task automatic upper_immediates();
    prog = '{u_op(7'b0110111, 1, 20'h80001), u_op(7'b0110111, 2, 20'h7ffff),
             u_op(7'b0010111, 3, 0), u_op(7'b0010111, 4, 20'hfffff),
             u_op(7'b0010111, 5, 20'h80000),
             {12'h0, 5'd1, 3'd2, 5'd6, 7'b0000011},  // load, unsupported
             i_op(0, 7, 6, 0)};
    run_program("lui_auipc", 64'h7fff_fff0, {$urandom, $urandom}, 0);
  endtask

  initial begin
    #(TOTAL_INSTS * 40 * 4);
    $display("timeout: the tests did not finish in %0d ns", TOTAL_INSTS * 160);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hb070_5dd6));
    entry    = '0;
    stackptr = '0;
    reset_and_start();
    immediate_ops();
    register_ops();
    dependent_chain();
    random_bus_stream();
    upper_immediates();
    errors += mem_model.errors;
    $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/core_pkg.sv
logic/bus_pkg.sv
logic/mem_ctrl.sv
logic/fetch_unit.sv
logic/inst_queue.sv
logic/exec_unit.sv
logic/core_top.sv
tb/tb_clock.sv
tb/bus_mem_model.sv
tb/core_tb.sv
